// File: build.f
verilog/replay_pkg.sv
verilog/pkt_word_fifo.sv
verilog/queue_writer.sv
verilog/queue_reader.sv
verilog/sram_arbiter.sv
verilog/sram_store.sv
verilog/replay_top.sv
tb/replay_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = replay_tb
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TB PASSED" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/replay_tb.sv
//####################
// Testbench for the packet replay buffer. Loads packets with replay off,
// checks drops, then replays and checks order, contents and contiguity.
//####################
`timescale 1ns/1ps

module replay_tb;
  import replay_pkg::*;

  localparam int MAX_PKTS   = 256;
  localparam int MAX_WORDS  = 4096;
  localparam int EXP_DEPTH  = 512;
  // Highest occupancy at which a packet is still accepted
  localparam int FILL_LIMIT = REGION_WORDS - MAX_PKT_WORDS;

  logic                       clk = 1'b0;
  logic                       rst;
  logic                       in_valid;
  pkt_word_t                  in_word;
  logic                       replay_en;
  logic                       out_valid;
  pkt_word_t                  out_word;
  drop_cnt_t [NUM_QUEUES-1:0] drop_count;
  logic                       fifo_overflow;

  integer seed = 32'h51eb75e3;

  // Generated packets, load phase first, then contention phase
  int                pkt_qid   [MAX_PKTS];
  int                pkt_len   [MAX_PKTS];
  int                pkt_first [MAX_PKTS];
  bit                pkt_keep  [MAX_PKTS];
  logic [DATA_W-1:0] word_data [MAX_WORDS];
  int                load_pkts;
  int                num_pkts;
  int                total_words;
  int                drops_exp [NUM_QUEUES];
  bit                gen_done = 1'b0;

  // Expected output words per queue
  pkt_word_t        exp_word [NUM_QUEUES][EXP_DEPTH];
  int               exp_wr   [NUM_QUEUES];
  int               exp_rd   [NUM_QUEUES];
  bit               in_pkt = 1'b0;
  logic [QID_W-1:0] pkt_q  = '0;

  always #5 clk = ~clk;

  replay_top replay_top_i (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .in_word       (in_word),
    .replay_en     (replay_en),
    .out_valid     (out_valid),
    .out_word      (out_word),
    .drop_count    (drop_count),
    .fifo_overflow (fifo_overflow)
  );

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic record_packet(input int q, input int len);
    pkt_qid[num_pkts]   = q;
    pkt_len[num_pkts]   = len;
    pkt_first[num_pkts] = total_words;
    for (int k = 0; k < len; k++) begin
      word_data[total_words + k] = $random(seed);
    end
    total_words += len;
    num_pkts++;
  endtask

  task automatic build_stimulus();
    int occ    [NUM_QUEUES];
    int budget [NUM_QUEUES];
    int q;
    int len;
    int q1_sent;
    num_pkts    = 0;
    total_words = 0;
    q1_sent     = 0;
    for (int i = 0; i < NUM_QUEUES; i++) begin
      occ[i]       = 0;
      budget[i]    = FILL_LIMIT;
      drops_exp[i] = 0;
    end
    // Load phase, mostly queue 1 until it is well past full
    while (q1_sent < 80) begin
      q   = (rand_below(4) == 0) ? rand_below(NUM_QUEUES) : 1;
      len = 1 + rand_below(MAX_PKT_WORDS);
      // Nothing is read yet, so occupancy only grows
      pkt_keep[num_pkts] = (occ[q] <= FILL_LIMIT);
      if (pkt_keep[num_pkts]) begin
        occ[q] += len;
      end else begin
        drops_exp[q]++;
      end
      if (q == 1) begin
        q1_sent += len;
      end
      record_packet(q, len);
    end
    load_pkts = num_pkts;
    // Contention phase starts from empty regions, budget keeps all stored
    for (int n = 0; n < 40; n++) begin
      q   = rand_below(NUM_QUEUES);
      len = 1 + rand_below(MAX_PKT_WORDS);
      if (len > budget[q]) begin
        len = budget[q];
      end
      if (len > 0) begin
        budget[q] -= len;
        pkt_keep[num_pkts] = 1'b1;
        record_packet(q, len);
      end
    end
  endtask

  task automatic send_packets(input int from, input int upto);
    pkt_word_t w;
    int        q;
    for (int p = from; p < upto; p++) begin
      q = pkt_qid[p];
      for (int k = 0; k < pkt_len[p]; k++) begin
        w.qid  = QID_W'(q);
        w.last = (k == pkt_len[p] - 1);
        w.data = word_data[pkt_first[p] + k];
        if (pkt_keep[p]) begin
          exp_word[q][exp_wr[q]] = w;
          exp_wr[q]++;
        end
        in_valid <= 1'b1;
        in_word  <= w;
        @(posedge clk);
        in_valid <= 1'b0;
        // At least two idle cycles per word
        repeat (2 + rand_below(3)) @(posedge clk);
      end
    end
  endtask

  task automatic check_drop_counts(input bit use_model);
    drop_cnt_t want;
    for (int i = 0; i < NUM_QUEUES; i++) begin
      want = use_model ? drop_cnt_t'(drops_exp[i]) : '0;
      assert (drop_count[i] == want)
        else fail_run($sformatf("Error: drop_count[%0d] expected %h got %h",
                                i, want, drop_count[i]));
    end
  endtask

  // Bounded wait for the writer to judge every dropped packet
  task automatic wait_drops();
    int tries;
    bit match;
    tries = 0;
    match = 1'b0;
    while (!match && tries < 400) begin
      @(negedge clk);
      match = 1'b1;
      for (int i = 0; i < NUM_QUEUES; i++) begin
        if (drop_count[i] != drop_cnt_t'(drops_exp[i])) begin
          match = 1'b0;
        end
      end
      tries++;
    end
    check_drop_counts(1'b1);
  endtask

  task automatic wait_drained();
    bit busy;
    busy = 1'b1;
    while (busy) begin
      @(negedge clk);
      busy = 1'b0;
      for (int i = 0; i < NUM_QUEUES; i++) begin
        if (exp_rd[i] != exp_wr[i]) begin
          busy = 1'b1;
        end
      end
    end
  endtask

  // Output monitor, compares each word with the per-queue model
  always @(negedge clk) begin
    pkt_word_t e;
    int        q;
    if (!rst && out_valid) begin
      q = int'(out_word.qid);
      assert (replay_en)
        else fail_run("Output word seen while replay was still disabled");
      if (in_pkt) begin
        assert (out_word.qid == pkt_q)
          else fail_run($sformatf("Error: out_word.qid expected %h got %h",
                                  pkt_q, out_word.qid));
      end
      assert (exp_rd[q] < exp_wr[q])
        else fail_run($sformatf("Error: out_word.qid %h has no stored packet pending",
                                out_word.qid));
      e = exp_word[q][exp_rd[q]];
      assert (out_word.data == e.data)
        else fail_run($sformatf("Error: out_word.data on queue %h expected %h got %h",
                                out_word.qid, e.data, out_word.data));
      assert (out_word.last == e.last)
        else fail_run($sformatf("Error: out_word.last on queue %h expected %h got %h",
                                out_word.qid, e.last, out_word.last));
      exp_rd[q]++;
      in_pkt = !out_word.last;
      pkt_q  = out_word.qid;
    end
  end

  // Watchdog sized from the generated traffic
  initial begin
    int limit;
    wait (gen_done);
    limit = total_words * 20 + 200;
    repeat (limit) @(posedge clk);
    $display("Timeout: run still busy after %0d cycles", limit);
    $display("TB FAILED");
    $fatal(1);
  end

  initial begin
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_word   = '0;
    replay_en = 1'b0;
    for (int i = 0; i < NUM_QUEUES; i++) begin
      exp_wr[i] = 0;
      exp_rd[i] = 0;
    end
    build_stimulus();
    gen_done = 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // Idle outputs after reset
    @(negedge clk);
    assert (out_valid == 1'b0)
      else fail_run($sformatf("Error: out_valid expected 0 got %h", out_valid));
    assert (fifo_overflow == 1'b0)
      else fail_run($sformatf("Error: fifo_overflow expected 0 got %h", fifo_overflow));
    check_drop_counts(1'b0);

    // Load with replay off, queue 1 overfills
    @(posedge clk);
    send_packets(0, load_pkts);
    wait_drops();

    // Replay everything that was stored
    @(posedge clk);
    replay_en <= 1'b1;
    wait_drained();
    repeat (30) @(negedge clk);
    check_drop_counts(1'b1);

    // Writer and reader contend for the memory
    @(posedge clk);
    send_packets(load_pkts, num_pkts);
    wait_drained();
    repeat (30) @(negedge clk);
    check_drop_counts(1'b1);
    assert (fifo_overflow == 1'b0)
      else fail_run($sformatf("Error: fifo_overflow expected 0 got %h", fifo_overflow));

    $display("TB PASSED");
    $finish;
  end

endmodule

// File: verilog/replay_top.sv
//####################
// Packet replay buffer top level.
// Input FIFO, queue writer and reader sharing one memory through an arbiter.
//####################
`timescale 1ns/1ps

module replay_top (
  input  logic                                               clk,
  input  logic                                               rst,
  input  logic                                               in_valid,
  input  replay_pkg::pkt_word_t                              in_word,
  input  logic                                               replay_en,
  output logic                                               out_valid,
  output replay_pkg::pkt_word_t                              out_word,
  output replay_pkg::drop_cnt_t [replay_pkg::NUM_QUEUES-1:0] drop_count,
  output logic                                               fifo_overflow
);
  import replay_pkg::*;

  pkt_word_t                    fifo_head;
  logic                         fifo_empty;
  logic                         fifo_pop;
  logic                         wr_req;
  logic                         wr_grant;
  mem_req_t                     wr_data;
  logic                         rd_req;
  logic                         rd_grant;
  mem_req_t                     rd_data_req;
  mem_req_t                     mem_req;
  mem_word_t                    rd_data;
  qptr_t [NUM_QUEUES-1:0]       head_ptr;
  qptr_t [NUM_QUEUES-1:0]       tail_ptr;

  pkt_word_fifo fifo_i (
    .clk       (clk),
    .rst       (rst),
    .push      (in_valid),
    .push_word (in_word),
    .pop       (fifo_pop),
    .head      (fifo_head),
    .empty     (fifo_empty),
    .overflow  (fifo_overflow)
  );

  queue_writer writer_i (
    .clk        (clk),
    .rst        (rst),
    .fifo_head  (fifo_head),
    .fifo_empty (fifo_empty),
    .fifo_pop   (fifo_pop),
    .req        (wr_req),
    .req_data   (wr_data),
    .grant      (wr_grant),
    .head_ptr   (head_ptr),
    .tail_ptr   (tail_ptr),
    .drop_count (drop_count)
  );

  queue_reader reader_i (
    .clk       (clk),
    .rst       (rst),
    .replay_en (replay_en),
    .tail_ptr  (tail_ptr),
    .head_ptr  (head_ptr),
    .req       (rd_req),
    .req_data  (rd_data_req),
    .grant     (rd_grant),
    .rd_data   (rd_data),
    .out_valid (out_valid),
    .out_word  (out_word)
  );

  sram_arbiter arbiter_i (
    .clk         (clk),
    .rst         (rst),
    .wr_req      (wr_req),
    .wr_data     (wr_data),
    .wr_grant    (wr_grant),
    .rd_req      (rd_req),
    .rd_data_req (rd_data_req),
    .rd_grant    (rd_grant),
    .mem_req     (mem_req)
  );

  sram_store store_i (
    .clk     (clk),
    .req     (mem_req),
    .rd_data (rd_data)
  );

endmodule

// File: verilog/sram_store.sv
//####################
// Single-port word memory, read data one cycle after the request.
//####################
`timescale 1ns/1ps

module sram_store (
  input  logic                  clk,
  input  replay_pkg::mem_req_t  req,
  output replay_pkg::mem_word_t rd_data
);
  import replay_pkg::*;

  mem_word_t mem [MEM_WORDS];

  always_ff @(posedge clk) begin
    if (req.we) begin
      mem[req.addr] <= req.wdata;
    end
    // Registered read of the addressed word
    rd_data <= mem[req.addr];
  end

endmodule

// File: verilog/sram_arbiter.sv
//####################
// Round-robin sharing of the memory port between writer and reader.
// Grants are combinational, the winner's request goes straight to memory.
//####################
`timescale 1ns/1ps

module sram_arbiter (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wr_req,
  input  replay_pkg::mem_req_t wr_data,
  output logic                 wr_grant,
  input  logic                 rd_req,
  input  replay_pkg::mem_req_t rd_data_req,
  output logic                 rd_grant,
  output replay_pkg::mem_req_t mem_req
);
  import replay_pkg::*;

  logic     last_was_rd;
  mem_req_t sel;

  // Lone requester wins, contention alternates
  assign wr_grant = wr_req && (!rd_req || last_was_rd);
  assign rd_grant = rd_req && (!wr_req || !last_was_rd);

  assign sel = rd_grant ? rd_data_req : wr_data;

  always_comb begin
    mem_req    = sel;
    // No write without a grant
    mem_req.we = sel.we && (wr_grant || rd_grant);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      last_was_rd <= 1'b0;
    end else begin
      if (wr_grant) begin
        last_was_rd <= 1'b0;
      end else if (rd_grant) begin
        last_was_rd <= 1'b1;
      end
    end
  end

endmodule

// File: verilog/queue_reader.sv
//####################
// Replays committed packets round-robin over the queues, one packet at a time.
// Words go out as strobes one cycle after their read grant.
//####################
`timescale 1ns/1ps

module queue_reader (
  input  logic                                           clk,
  input  logic                                           rst,
  input  logic                                           replay_en,
  input  replay_pkg::qptr_t [replay_pkg::NUM_QUEUES-1:0] tail_ptr,
  output replay_pkg::qptr_t [replay_pkg::NUM_QUEUES-1:0] head_ptr,
  output logic                                           req,
  output replay_pkg::mem_req_t                           req_data,
  input  logic                                           grant,
  input  replay_pkg::mem_word_t                          rd_data,
  output logic                                           out_valid,
  output replay_pkg::pkt_word_t                          out_word
);
  import replay_pkg::*;

  typedef enum logic {
    R_IDLE,
    R_READ
  } rd_state_t;

  rd_state_t        state;
  logic [QID_W-1:0] cur_q;
  logic [QID_W-1:0] next_q;
  logic             found;
  logic [QID_W-1:0] out_qid;
  logic             pkt_done;

  // Search starts after the queue served last
  always_comb begin
    logic [QID_W-1:0] cand;
    found  = 1'b0;
    next_q = cur_q;
    for (int i = 1; i <= NUM_QUEUES; i++) begin
      cand = cur_q + QID_W'(i);
      if (!found && (head_ptr[cand] != tail_ptr[cand])) begin
        found  = 1'b1;
        next_q = cand;
      end
    end
  end

  // Last word of the packet is on the output now
  assign pkt_done = out_valid && rd_data.last;
  assign req      = (state == R_READ) && !pkt_done;

  always_comb begin
    req_data.we    = 1'b0;
    req_data.addr  = {cur_q, head_ptr[cur_q][REGION_AW-1:0]};
    req_data.wdata = '0;
  end

  always_comb begin
    out_word.qid  = out_qid;
    out_word.last = rd_data.last;
    out_word.data = rd_data.data;
  end

  // Queue tag for the word read at the grant
  always_ff @(posedge clk) begin
    if (grant) begin
      out_qid <= cur_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= R_IDLE;
      cur_q     <= '0;
      head_ptr  <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= grant;
      case (state)
        R_IDLE: begin
          if (replay_en && found) begin
            cur_q <= next_q;
            state <= R_READ;
          end
        end
        R_READ: begin
          if (pkt_done) begin
            state <= R_IDLE;
          end else if (grant) begin
            head_ptr[cur_q] <= head_ptr[cur_q] + 1'b1;
          end
        end
        default: state <= R_IDLE;
      endcase
    end
  end

endmodule

// File: verilog/queue_writer.sv
//####################
// Moves packets from the input FIFO into per-queue ring regions.
// Drops a whole packet when its queue lacks room, commits tails per packet.
//####################
`timescale 1ns/1ps

module queue_writer (
  input  logic                                            clk,
  input  logic                                            rst,
  input  replay_pkg::pkt_word_t                           fifo_head,
  input  logic                                            fifo_empty,
  output logic                                            fifo_pop,
  output logic                                            req,
  output replay_pkg::mem_req_t                            req_data,
  input  logic                                            grant,
  input  replay_pkg::qptr_t [replay_pkg::NUM_QUEUES-1:0]  head_ptr,
  output replay_pkg::qptr_t [replay_pkg::NUM_QUEUES-1:0]  tail_ptr,
  output replay_pkg::drop_cnt_t [replay_pkg::NUM_QUEUES-1:0] drop_count
);
  import replay_pkg::*;

  typedef enum logic [1:0] {
    W_IDLE,
    W_STORE,
    W_DROP
  } wr_state_t;

  wr_state_t        state;
  logic [QID_W-1:0] cur_q;
  qptr_t            wr_ptr;
  logic [QID_W-1:0] head_q;
  qptr_t            occ;
  qptr_t            room;
  logic             room_ok;

  // Drop decision for the packet at the FIFO head
  assign head_q  = fifo_head.qid;
  assign occ     = tail_ptr[head_q] - head_ptr[head_q];
  assign room    = qptr_t'(REGION_WORDS) - occ;
  assign room_ok = (room >= qptr_t'(MAX_PKT_WORDS));

  always_comb begin
    req_data.we         = 1'b1;
    req_data.addr       = {cur_q, wr_ptr[REGION_AW-1:0]};
    req_data.wdata.last = fifo_head.last;
    req_data.wdata.data = fifo_head.data;
  end

  assign req = (state == W_STORE) && !fifo_empty;

  // Stored words leave on their grant, dropped words one per cycle
  always_comb begin
    case (state)
      W_IDLE:  fifo_pop = !fifo_empty && !room_ok;
      W_STORE: fifo_pop = grant;
      W_DROP:  fifo_pop = !fifo_empty;
      default: fifo_pop = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= W_IDLE;
      cur_q      <= '0;
      wr_ptr     <= '0;
      tail_ptr   <= '0;
      drop_count <= '0;
    end else begin
      case (state)
        W_IDLE: begin
          if (!fifo_empty) begin
            cur_q <= head_q;
            if (room_ok) begin
              // Work from the committed tail
              wr_ptr <= tail_ptr[head_q];
              state  <= W_STORE;
            end else begin
              if (drop_count[head_q] != '1) begin
                drop_count[head_q] <= drop_count[head_q] + 1'b1;
              end
              // Single-word packets are gone already
              if (!fifo_head.last) begin
                state <= W_DROP;
              end
            end
          end
        end
        W_STORE: begin
          if (grant) begin
            wr_ptr <= wr_ptr + 1'b1;
            if (fifo_head.last) begin
              // Publish the whole packet at once
              tail_ptr[cur_q] <= wr_ptr + 1'b1;
              state           <= W_IDLE;
            end
          end
        end
        W_DROP: begin
          if (!fifo_empty && fifo_head.last) begin
            state <= W_IDLE;
          end
        end
        default: state <= W_IDLE;
      endcase
    end
  end

endmodule

// File: verilog/pkt_word_fifo.sv
//####################
// Input FIFO for tagged packet words, fed by single-cycle strobes.
// A push into a full FIFO loses the word and sets a sticky flag.
//####################
`timescale 1ns/1ps

module pkt_word_fifo (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  push,
  input  replay_pkg::pkt_word_t push_word,
  input  logic                  pop,
  output replay_pkg::pkt_word_t head,
  output logic                  empty,
  output logic                  overflow
);
  import replay_pkg::*;

  pkt_word_t          mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_idx;
  logic [FIFO_AW-1:0] rd_idx;
  logic [FIFO_AW:0]   count;
  logic               full;
  logic               push_ok;
  logic               pop_ok;

  assign full    = (count == FIFO_DEPTH);
  assign empty   = (count == '0);
  assign push_ok = push && !full;
  assign pop_ok  = pop && !empty;
  assign head    = mem[rd_idx];

  // Storage array
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_idx] <= push_word;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_idx   <= '0;
      rd_idx   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_idx <= wr_idx + 1'b1;
      end
      if (pop_ok) begin
        rd_idx <= rd_idx + 1'b1;
      end
      count <= count + {{FIFO_AW{1'b0}}, push_ok} - {{FIFO_AW{1'b0}}, pop_ok};
      // Sticky until reset
      if (push && full) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

// File: verilog/replay_pkg.sv
//####################
// Shared sizes and types for the packet replay buffer.
// Imported by every RTL block and by the testbench.
//####################

package replay_pkg;

  // Queue and payload sizes
  localparam int NUM_QUEUES    = 4;
  localparam int QID_W         = 2;
  localparam int DATA_W        = 32;

  // One ring region per queue in a 256-word memory
  localparam int REGION_WORDS  = 64;
  localparam int REGION_AW     = 6;
  localparam int MEM_WORDS     = 256;
  localparam int MEM_ADDR_W    = QID_W + REGION_AW;

  // Packets are 1 to 16 words by contract
  localparam int MAX_PKT_WORDS = 16;

  localparam int FIFO_DEPTH    = 32;
  localparam int FIFO_AW       = 5;

  // Ring pointer, top bit marks the wrap
  localparam int PTR_W         = REGION_AW + 1;
  typedef logic [PTR_W-1:0] qptr_t;

  typedef struct packed {
    logic [QID_W-1:0]  qid;
    logic              last;
    logic [DATA_W-1:0] data;
  } pkt_word_t;

  typedef struct packed {
    logic              last;
    logic [DATA_W-1:0] data;
  } mem_word_t;

  typedef struct packed {
    logic                  we;
    logic [MEM_ADDR_W-1:0] addr;
    mem_word_t             wdata;
  } mem_req_t;

  // Saturating drop counter
  typedef logic [15:0] drop_cnt_t;

endpackage
